// ==== design/dbg_pkg.sv ====
package dbg_pkg;

	// Payload widths
	typedef logic [7:0] sample_t;
	typedef logic [31:0] count_t;
	typedef logic [3:0] ir_t;

	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_t;

	// Instruction codes
	localparam ir_t IR_IDCODE   = 4'h1;
	localparam ir_t IR_CTRL     = 4'h2;
	localparam ir_t IR_STATUS   = 4'h3;
	localparam ir_t IR_MEM_ADDR = 4'h4;
	localparam ir_t IR_MEM_DATA = 4'h5;
	localparam ir_t IR_BYPASS   = 4'hF;

	// Bit 0 set as the standard requires
	localparam logic [31:0] IDCODE_VAL = 32'h1DB9_0A5F;

	localparam int CTRL_W   = 8;
	localparam int STATUS_W = 65;
	localparam int DR_MAX_W = 65;

endpackage

// ==== design/jtag_tap.sv ====
`timescale 1ns/1ns
`default_nettype none

module jtag_tap (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	output logic tdo_o,
	output dbg_pkg::ir_t ir_o,
	output logic capture_dr_o,
	output logic update_dr_o,
	output logic [dbg_pkg::DR_MAX_W-1:0] dr_shift_o,
	input wire logic [dbg_pkg::DR_MAX_W-1:0] dr_capture_i
);
	localparam int DRW = dbg_pkg::DR_MAX_W;
	localparam int CNT_W = $clog2(DRW + 1);

	logic [1:0] tck_sync_q;
	logic [1:0] tms_sync_q;
	logic [1:0] tdi_sync_q;
	logic tck_prev_q;
	logic tck_rise;
	logic tck_fall;

	dbg_pkg::tap_state_t state_q;
	dbg_pkg::tap_state_t state_d;

	dbg_pkg::ir_t ir_sr;
	logic [DRW-1:0] dr_sr;
	logic [CNT_W-1:0] shift_cnt_q;
	logic bypass_q;
	logic is_bypass;

	// Two flops per pin, then compare against the previous TCK sample
	always_ff @(posedge clk) begin
		if (reset_i) begin
			tck_sync_q <= '0;
			tms_sync_q <= '1;
			tdi_sync_q <= '0;
			tck_prev_q <= 1'b0;
		end else begin
			tck_sync_q <= {tck_sync_q[0], tck_i};
			tms_sync_q <= {tms_sync_q[0], tms_i};
			tdi_sync_q <= {tdi_sync_q[0], tdi_i};
			tck_prev_q <= tck_sync_q[1];
		end
	end

	assign tck_rise = tck_sync_q[1] & ~tck_prev_q;
	assign tck_fall = ~tck_sync_q[1] & tck_prev_q;

	always_comb begin
		case (state_q)
			dbg_pkg::TEST_LOGIC_RESET:
				state_d = tms_sync_q[1] ? dbg_pkg::TEST_LOGIC_RESET : dbg_pkg::RUN_TEST_IDLE;
			dbg_pkg::RUN_TEST_IDLE:
				state_d = tms_sync_q[1] ? dbg_pkg::SELECT_DR : dbg_pkg::RUN_TEST_IDLE;
			dbg_pkg::SELECT_DR:
				state_d = tms_sync_q[1] ? dbg_pkg::SELECT_IR : dbg_pkg::CAPTURE_DR;
			dbg_pkg::CAPTURE_DR, dbg_pkg::SHIFT_DR:
				state_d = tms_sync_q[1] ? dbg_pkg::EXIT1_DR : dbg_pkg::SHIFT_DR;
			dbg_pkg::EXIT1_DR:
				state_d = tms_sync_q[1] ? dbg_pkg::UPDATE_DR : dbg_pkg::PAUSE_DR;
			dbg_pkg::PAUSE_DR:
				state_d = tms_sync_q[1] ? dbg_pkg::EXIT2_DR : dbg_pkg::PAUSE_DR;
			dbg_pkg::EXIT2_DR:
				state_d = tms_sync_q[1] ? dbg_pkg::UPDATE_DR : dbg_pkg::SHIFT_DR;
			dbg_pkg::SELECT_IR:
				state_d = tms_sync_q[1] ? dbg_pkg::TEST_LOGIC_RESET : dbg_pkg::CAPTURE_IR;
			dbg_pkg::CAPTURE_IR, dbg_pkg::SHIFT_IR:
				state_d = tms_sync_q[1] ? dbg_pkg::EXIT1_IR : dbg_pkg::SHIFT_IR;
			dbg_pkg::EXIT1_IR:
				state_d = tms_sync_q[1] ? dbg_pkg::UPDATE_IR : dbg_pkg::PAUSE_IR;
			dbg_pkg::PAUSE_IR:
				state_d = tms_sync_q[1] ? dbg_pkg::EXIT2_IR : dbg_pkg::PAUSE_IR;
			dbg_pkg::EXIT2_IR:
				state_d = tms_sync_q[1] ? dbg_pkg::UPDATE_IR : dbg_pkg::SHIFT_IR;
			default:
				state_d = tms_sync_q[1] ? dbg_pkg::SELECT_DR : dbg_pkg::RUN_TEST_IDLE;
		endcase
	end

	assign is_bypass = (ir_o == dbg_pkg::IR_BYPASS);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= dbg_pkg::TEST_LOGIC_RESET;
			ir_o <= dbg_pkg::IR_IDCODE;
			shift_cnt_q <= '0;
			bypass_q <= 1'b0;
			tdo_o <= 1'b0;
		end else begin
			if (state_q == dbg_pkg::TEST_LOGIC_RESET)
				ir_o <= dbg_pkg::IR_IDCODE;
			if (tck_rise) begin
				state_q <= state_d;
				case (state_q)
					dbg_pkg::CAPTURE_DR: begin
						shift_cnt_q <= '0;
						bypass_q <= 1'b0;
					end
					dbg_pkg::SHIFT_DR: begin
						bypass_q <= tdi_sync_q[1];
						if (shift_cnt_q != CNT_W'(DRW))
							shift_cnt_q <= shift_cnt_q + 1'b1;
					end
					dbg_pkg::UPDATE_IR: ir_o <= ir_sr;
					default: ;
				endcase
			end
			if (tck_fall) begin
				case (state_q)
					dbg_pkg::SHIFT_IR: tdo_o <= ir_sr[0];
					dbg_pkg::SHIFT_DR: tdo_o <= is_bypass ? bypass_q : dr_sr[0];
					default: tdo_o <= 1'b0;
				endcase
			end
		end
	end

	// Shift data enters at the top and is right-aligned on the way out
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			case (state_q)
				dbg_pkg::CAPTURE_IR: ir_sr <= 4'b0001;
				dbg_pkg::SHIFT_IR: ir_sr <= {tdi_sync_q[1], ir_sr[3:1]};
				dbg_pkg::CAPTURE_DR: begin
					if (ir_o == dbg_pkg::IR_IDCODE)
						dr_sr <= {{(DRW - 32){1'b0}}, dbg_pkg::IDCODE_VAL};
					else
						dr_sr <= dr_capture_i;
				end
				dbg_pkg::SHIFT_DR: dr_sr <= {tdi_sync_q[1], dr_sr[DRW-1:1]};
				default: ;
			endcase
		end
	end

	assign capture_dr_o = tck_rise && (state_q == dbg_pkg::CAPTURE_DR);
	assign update_dr_o = tck_rise && (state_q == dbg_pkg::UPDATE_DR);
	assign dr_shift_o = dr_sr >> (DRW - shift_cnt_q);

	a_state_known: assert property (@(posedge clk) disable iff (reset_i)
		!$isunknown(state_q) && !$isunknown(ir_o));

endmodule

`default_nettype wire

// ==== design/dbg_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module dbg_regfile #(
	parameter int ADDR_W = 6
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire dbg_pkg::ir_t ir_i,
	input wire logic capture_dr_i,
	input wire logic update_dr_i,
	input wire logic [dbg_pkg::DR_MAX_W-1:0] dr_shift_i,
	output logic [dbg_pkg::DR_MAX_W-1:0] dr_capture_o,
	output logic rd_req_o,
	output logic [ADDR_W-1:0] rd_addr_o,
	input wire logic rd_ack_i,
	input wire dbg_pkg::sample_t rd_data_i,
	output logic cap_arm_o,
	output logic prbs_en_o,
	input wire logic cap_done_i,
	input wire dbg_pkg::count_t prbs_correct_i,
	input wire dbg_pkg::count_t prbs_total_i
);
	localparam int SAMPLE_W = $bits(dbg_pkg::sample_t);

	logic [dbg_pkg::CTRL_W-1:0] ctrl_q;
	logic [dbg_pkg::STATUS_W-1:0] status;
	dbg_pkg::sample_t data_q;

	// CTRL bit 0 is the arm strobe and never stored
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ctrl_q <= '0;
			cap_arm_o <= 1'b0;
		end else begin
			cap_arm_o <= 1'b0;
			if (update_dr_i && ir_i == dbg_pkg::IR_CTRL) begin
				ctrl_q <= {dr_shift_i[dbg_pkg::CTRL_W-1:1], 1'b0};
				cap_arm_o <= dr_shift_i[0];
			end
		end
	end

	assign prbs_en_o = ctrl_q[1];

	// Read request stays up until the buffer grants it
	always_ff @(posedge clk) begin
		if (reset_i) begin
			rd_req_o <= 1'b0;
			rd_addr_o <= '0;
		end else begin
			if (rd_ack_i)
				rd_req_o <= 1'b0;
			if (update_dr_i && ir_i == dbg_pkg::IR_MEM_ADDR) begin
				rd_addr_o <= dr_shift_i[ADDR_W-1:0];
				rd_req_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_ack_i)
			data_q <= rd_data_i;
	end

	// Total in the low word, then correct, then done
	assign status = {cap_done_i, prbs_correct_i, prbs_total_i};

	always_comb begin
		dr_capture_o = '0;
		case (ir_i)
			dbg_pkg::IR_CTRL: dr_capture_o[dbg_pkg::CTRL_W-1:0] = ctrl_q;
			dbg_pkg::IR_STATUS: dr_capture_o[dbg_pkg::STATUS_W-1:0] = status;
			dbg_pkg::IR_MEM_ADDR: dr_capture_o[ADDR_W-1:0] = rd_addr_o;
			dbg_pkg::IR_MEM_DATA: dr_capture_o[SAMPLE_W-1:0] = data_q;
			default: dr_capture_o = '0;
		endcase
	end

	// The byte must be back before the host captures it
	a_read_done: assert property (@(posedge clk) disable iff (reset_i)
		(capture_dr_i && ir_i == dbg_pkg::IR_MEM_DATA) |-> !rd_req_o);

endmodule

`default_nettype wire

// ==== design/sample_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_buffer #(
	parameter int ADDR_W = 6
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic wr_en_i,
	input wire logic [ADDR_W-1:0] wr_addr_i,
	input wire dbg_pkg::sample_t wr_data_i,
	input wire logic rd_req_i,
	input wire logic [ADDR_W-1:0] rd_addr_i,
	output logic rd_ack_o,
	output dbg_pkg::sample_t rd_data_o
);
	localparam int DEPTH = 2 ** ADDR_W;

	dbg_pkg::sample_t mem [DEPTH];
	logic [ADDR_W-1:0] port_addr;
	logic rd_grant;

	// One port, writer has fixed priority
	always_comb begin
		rd_grant = 1'b0;
		port_addr = rd_addr_i;
		if (wr_en_i)
			port_addr = wr_addr_i;
		else if (rd_req_i)
			rd_grant = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[port_addr] <= wr_data_i;
	end

	assign rd_data_o = mem[port_addr];
	assign rd_ack_o = rd_grant;

	a_no_collision: assert property (@(posedge clk) disable iff (reset_i)
		!(rd_ack_o && wr_en_i));

	// Requester must hold its address while waiting
	a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
		(rd_req_i && !rd_ack_o) |=> (rd_req_i && $stable(rd_addr_i)));

endmodule

`default_nettype wire

// ==== design/capture_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module capture_engine #(
	parameter int ADDR_W = 6
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic arm_i,
	input wire dbg_pkg::sample_t sample_i,
	input wire logic sample_valid_i,
	output logic wr_en_o,
	output logic [ADDR_W-1:0] wr_addr_o,
	output dbg_pkg::sample_t wr_data_o,
	output logic done_o
);
	logic active_q;
	logic [ADDR_W-1:0] addr_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			active_q <= 1'b0;
			addr_q <= '0;
			wr_en_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			wr_en_o <= 1'b0;
			if (arm_i) begin
				active_q <= 1'b1;
				addr_q <= '0;
				done_o <= 1'b0;
			end else if (active_q && sample_valid_i) begin
				wr_en_o <= 1'b1;
				addr_q <= addr_q + 1'b1;
				// Last slot ends the capture
				if (addr_q == '1) begin
					active_q <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active_q && sample_valid_i) begin
			wr_addr_o <= addr_q;
			wr_data_o <= sample_i;
		end
	end

endmodule

`default_nettype wire

// ==== design/prbs_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module prbs_checker (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic en_i,
	input wire logic rx_bit_i,
	input wire logic rx_valid_i,
	output dbg_pkg::count_t correct_o,
	output dbg_pkg::count_t total_o
);
	// Newest bit at index 0
	logic [6:0] hist_q;
	logic [2:0] seen_q;
	logic predicted;
	logic primed;

	// x^7 + x^6 + 1
	assign predicted = hist_q[5] ^ hist_q[6];
	assign primed = (seen_q == 3'd7);

	always_ff @(posedge clk) begin
		if (reset_i || !en_i) begin
			hist_q <= '0;
			seen_q <= '0;
			correct_o <= '0;
			total_o <= '0;
		end else if (rx_valid_i) begin
			hist_q <= {hist_q[5:0], rx_bit_i};
			if (primed) begin
				total_o <= total_o + 1'b1;
				if (rx_bit_i == predicted)
					correct_o <= correct_o + 1'b1;
			end else begin
				seen_q <= seen_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/debug_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_top #(
	parameter int ADDR_W = 6
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	output logic tdo_o,
	input wire logic rx_bit_i,
	input wire logic rx_valid_i,
	input wire dbg_pkg::sample_t sample_i,
	input wire logic sample_valid_i
);
	dbg_pkg::ir_t ir;
	logic capture_dr;
	logic update_dr;
	logic [dbg_pkg::DR_MAX_W-1:0] dr_shift;
	logic [dbg_pkg::DR_MAX_W-1:0] dr_capture;

	logic rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic rd_ack;
	dbg_pkg::sample_t rd_data;

	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	dbg_pkg::sample_t wr_data;

	logic cap_arm;
	logic cap_done;
	logic prbs_en;
	dbg_pkg::count_t prbs_correct;
	dbg_pkg::count_t prbs_total;

	jtag_tap u_tap (
		.clk(clk), .reset_i(reset_i),
		.tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i), .tdo_o(tdo_o),
		.ir_o(ir), .capture_dr_o(capture_dr), .update_dr_o(update_dr),
		.dr_shift_o(dr_shift), .dr_capture_i(dr_capture)
	);

	dbg_regfile #(.ADDR_W(ADDR_W)) u_regfile (
		.clk(clk), .reset_i(reset_i),
		.ir_i(ir), .capture_dr_i(capture_dr), .update_dr_i(update_dr),
		.dr_shift_i(dr_shift), .dr_capture_o(dr_capture),
		.rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_ack_i(rd_ack), .rd_data_i(rd_data),
		.cap_arm_o(cap_arm), .prbs_en_o(prbs_en), .cap_done_i(cap_done),
		.prbs_correct_i(prbs_correct), .prbs_total_i(prbs_total)
	);

	sample_buffer #(.ADDR_W(ADDR_W)) u_buffer (
		.clk(clk), .reset_i(reset_i),
		.wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_ack_o(rd_ack), .rd_data_o(rd_data)
	);

	capture_engine #(.ADDR_W(ADDR_W)) u_capture (
		.clk(clk), .reset_i(reset_i), .arm_i(cap_arm),
		.sample_i(sample_i), .sample_valid_i(sample_valid_i),
		.wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .done_o(cap_done)
	);

	prbs_checker u_prbs (
		.clk(clk), .reset_i(reset_i), .en_i(prbs_en),
		.rx_bit_i(rx_bit_i), .rx_valid_i(rx_valid_i),
		.correct_o(prbs_correct), .total_o(prbs_total)
	);

endmodule

`default_nettype wire

// ==== verif/debug_checker.sv ====
`timescale 1ns/1ns

module debug_checker #(
	parameter int ADDR_W = 6
) (
	input logic clk,
	input logic reset_i,
	input logic rx_bit_i,
	input logic rx_valid_i,
	input dbg_pkg::sample_t sample_i,
	input logic sample_valid_i,
	input logic arm_mark_i,
	input logic res_stb_i,
	input logic [2:0] res_kind_i,
	input logic [31:0] res_arg_i,
	input logic [dbg_pkg::DR_MAX_W-1:0] res_val_i,
	output int err_count_o,
	output int check_count_o
);
	localparam int DEPTH = 2 ** ADDR_W;
	localparam int RX_MAX = 1024;

	// Result kinds, same codes as in debug_tb
	localparam logic [2:0] K_IDCODE = 3'd0;
	localparam logic [2:0] K_BYPASS = 3'd1;
	localparam logic [2:0] K_CTRL = 3'd2;
	localparam logic [2:0] K_PRBS = 3'd3;
	localparam logic [2:0] K_SAMPLE = 3'd4;

	logic rx_bits [RX_MAX];
	int rx_n;
	dbg_pkg::sample_t shadow [DEPTH];
	int shadow_n;

	initial begin
		err_count_o = 0;
		check_count_o = 0;
	end

	// Self-synchronizing PRBS7 rule over every bit seen since reset
	function automatic dbg_pkg::count_t prbs_reference(input bit want_correct);
		dbg_pkg::count_t correct;
		dbg_pkg::count_t total;
		int i;
		correct = '0;
		total = '0;
		for (i = 7; i < rx_n; i++) begin
			total = total + 1;
			if (rx_bits[i] == (rx_bits[i-6] ^ rx_bits[i-7]))
				correct = correct + 1;
		end
		return want_correct ? correct : total;
	endfunction

	task automatic expect_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count_o = check_count_o + 1;
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			err_count_o = err_count_o + 1;
		end
	endtask

	// Receive stream and the samples that follow each arm
	always @(posedge clk) begin
		if (reset_i) begin
			rx_n = 0;
			shadow_n = DEPTH;
		end else begin
			if (rx_valid_i && rx_n < RX_MAX) begin
				rx_bits[rx_n] = rx_bit_i;
				rx_n = rx_n + 1;
			end
			if (arm_mark_i) begin
				shadow_n = 0;
			end else if (sample_valid_i && shadow_n < DEPTH) begin
				shadow[shadow_n] = sample_i;
				shadow_n = shadow_n + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset_i && res_stb_i) begin
			case (res_kind_i)
				K_IDCODE: expect_hex("idcode", res_val_i[31:0], dbg_pkg::IDCODE_VAL);
				K_BYPASS: expect_hex("bypass tdo", res_val_i[15:0], {res_arg_i[14:0], 1'b0});
				K_CTRL: expect_hex("ctrl", res_val_i[7:0], res_arg_i[7:0] & 8'hFE);
				K_PRBS: begin
					expect_hex("status.total", res_val_i[31:0], prbs_reference(1'b0));
					expect_hex("status.correct", res_val_i[63:32], prbs_reference(1'b1));
				end
				K_SAMPLE: expect_hex($sformatf("mem_data[%0d]", res_arg_i), res_val_i[7:0],
					shadow[res_arg_i[ADDR_W-1:0]]);
				default: begin
					$display("checker received an unknown result kind %0d", res_kind_i);
					err_count_o = err_count_o + 1;
				end
			endcase
		end
	end

endmodule

// ==== verif/debug_tb.sv ====
`timescale 1ns/1ns

module debug_tb;
	localparam int ADDR_W = 6;
	localparam int DEPTH = 2 ** ADDR_W;
	localparam int PRBS_BITS = 300;
	localparam int CAP_SAMPLES = 80;
	localparam int POLL_MAX = 4;
	localparam int HALF_TCK = 8;

	// TCK cycles per scan, then per test
	localparam int IR_TCK = 10;
	localparam int RESET_TCK = 6;
	localparam int T1_TCK = RESET_TCK + IR_TCK + (32 + 5) + (16 + 5);
	localparam int T2_TCK = IR_TCK + 2 * (8 + 5);
	localparam int T3_TCK = 2 * IR_TCK + (8 + 5) + (65 + 5);
	localparam int T4_TCK = 2 * IR_TCK + (8 + 5) + POLL_MAX * (65 + 5)
		+ DEPTH * (2 * IR_TCK + (ADDR_W + 5) + (8 + 5));
	localparam int T5_TCK = 3 * IR_TCK + (8 + 5) + (ADDR_W + 5) + (8 + 5);
	localparam int SCAN_TCK = T1_TCK + T2_TCK + T3_TCK + T4_TCK + T5_TCK;
	localparam int STIM_CLK = 4 + PRBS_BITS + 3 * CAP_SAMPLES + 130 + (DEPTH + 8) + 20;
	localparam int LIMIT = (SCAN_TCK * 2 * HALF_TCK + STIM_CLK) * 5 / 4;

	localparam logic [2:0] K_IDCODE = 3'd0;
	localparam logic [2:0] K_BYPASS = 3'd1;
	localparam logic [2:0] K_CTRL = 3'd2;
	localparam logic [2:0] K_PRBS = 3'd3;
	localparam logic [2:0] K_SAMPLE = 3'd4;

	logic clk;
	logic reset;
	logic tck;
	logic tms;
	logic tdi;
	logic tdo;
	logic rx_bit;
	logic rx_valid;
	dbg_pkg::sample_t sample;
	logic sample_valid;
	logic arm_mark;
	logic res_stb;
	logic [2:0] res_kind;
	logic [31:0] res_arg;
	logic [dbg_pkg::DR_MAX_W-1:0] res_val;
	int err_count;
	int check_count;
	logic [31:0] rng;
	int err_mark;
	int tests_run;
	int tests_failed;
	int other_errors;
	int cycles;

	debug_top #(.ADDR_W(ADDR_W)) dut (
		.clk(clk), .reset_i(reset),
		.tck_i(tck), .tms_i(tms), .tdi_i(tdi), .tdo_o(tdo),
		.rx_bit_i(rx_bit), .rx_valid_i(rx_valid),
		.sample_i(sample), .sample_valid_i(sample_valid)
	);

	debug_checker #(.ADDR_W(ADDR_W)) chk (
		.clk(clk), .reset_i(reset),
		.rx_bit_i(rx_bit), .rx_valid_i(rx_valid),
		.sample_i(sample), .sample_valid_i(sample_valid),
		.arm_mark_i(arm_mark), .res_stb_i(res_stb), .res_kind_i(res_kind),
		.res_arg_i(res_arg), .res_val_i(res_val),
		.err_count_o(err_count), .check_count_o(check_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Leaves the caller 2 ns past a rising clk edge
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// TDO is sampled at the end of the low phase, just before TCK rises
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		tms = tms_v;
		tdi = tdi_v;
		step(HALF_TCK);
		tdo_v = tdo;
		tck = 1'b1;
		step(HALF_TCK);
		tck = 1'b0;
	endtask

	// Five ones into Test-Logic-Reset, then a zero to park in Run-Test/Idle
	task automatic jtag_reset();
		logic unused;
		repeat (5) tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic jtag_ir(input dbg_pkg::ir_t code);
		logic unused;
		int i;
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (i = 0; i < 4; i++)
			tck_cycle(i == 3, code[i], unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic jtag_dr(input int n, input logic [dbg_pkg::DR_MAX_W-1:0] din,
		output logic [dbg_pkg::DR_MAX_W-1:0] dout);
		logic bit_out;
		int i;
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (i = 0; i < n; i++) begin
			tck_cycle(i == n - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic report(input logic [2:0] kind, input logic [31:0] arg,
		input logic [dbg_pkg::DR_MAX_W-1:0] val);
		res_kind = kind;
		res_arg = arg;
		res_val = val;
		res_stb = 1'b1;
		step(1);
		res_stb = 1'b0;
	endtask

	task automatic read_sample(input int addr, output dbg_pkg::sample_t value);
		logic [dbg_pkg::DR_MAX_W-1:0] dout;
		jtag_ir(dbg_pkg::IR_MEM_ADDR);
		jtag_dr(ADDR_W, addr, dout);
		jtag_ir(dbg_pkg::IR_MEM_DATA);
		jtag_dr(8, '0, dout);
		value = dout[7:0];
	endtask

	task automatic end_test(input string name);
		int now;
		step(2);
		now = err_count + other_errors;
		tests_run++;
		if (now == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, now - err_mark);
		end
		err_mark = now;
	endtask

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d clk cycles", LIMIT);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [dbg_pkg::DR_MAX_W-1:0] dout;
		dbg_pkg::sample_t byte_v;
		logic [15:0] pattern;
		logic [6:0] lfsr;
		logic b;
		bit done;
		int polls;
		int i;
		reset = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		rx_bit = 1'b0;
		rx_valid = 1'b0;
		sample = '0;
		sample_valid = 1'b0;
		arm_mark = 1'b0;
		res_stb = 1'b0;
		res_kind = '0;
		res_arg = '0;
		res_val = '0;
		rng = 32'h6983;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		other_errors = 0;
		step(2);
		reset = 1'b0;
		jtag_reset();

		jtag_dr(32, '0, dout);
		report(K_IDCODE, 0, dout);
		jtag_ir(dbg_pkg::IR_BYPASS);
		pattern = 16'hC3A5;
		jtag_dr(16, pattern, dout);
		report(K_BYPASS, pattern, dout);
		end_test("idcode_bypass");

		// Bit 0 set on the write, clear on the read-back scan
		jtag_ir(dbg_pkg::IR_CTRL);
		jtag_dr(8, 'hB5, dout);
		jtag_dr(8, 'hB4, dout);
		report(K_CTRL, 32'hB5, dout);
		end_test("ctrl");

		jtag_dr(8, 'h02, dout);
		lfsr = 7'h7F;
		for (i = 0; i < PRBS_BITS; i++) begin
			b = lfsr[6] ^ lfsr[5];
			lfsr = {lfsr[5:0], b};
			rng = xorshift(rng);
			rx_bit = b ^ (rng[4:0] == 5'd0);
			rx_valid = 1'b1;
			step(1);
		end
		rx_valid = 1'b0;
		step(2);
		jtag_ir(dbg_pkg::IR_STATUS);
		jtag_dr(65, '0, dout);
		report(K_PRBS, 0, dout);
		end_test("prbs");

		jtag_ir(dbg_pkg::IR_CTRL);
		jtag_dr(8, 'h01, dout);
		arm_mark = 1'b1;
		step(1);
		arm_mark = 1'b0;
		for (i = 0; i < CAP_SAMPLES; i++) begin
			rng = xorshift(rng);
			sample = rng[7:0];
			sample_valid = 1'b1;
			step(1);
			sample_valid = 1'b0;
			step(1);
		end
		jtag_ir(dbg_pkg::IR_STATUS);
		done = 1'b0;
		polls = 0;
		while (!done && polls < POLL_MAX) begin
			jtag_dr(65, '0, dout);
			done = dout[64];
			polls++;
		end
		if (!done) begin
			$display("capture done flag still low after %0d status reads", polls);
			other_errors++;
		end
		for (i = 0; i < DEPTH; i++) begin
			read_sample(i, byte_v);
			report(K_SAMPLE, i, byte_v);
		end
		end_test("capture");

		// Address update lands while back-to-back writes hold the buffer port
		jtag_ir(dbg_pkg::IR_CTRL);
		jtag_dr(8, 'h01, dout);
		jtag_ir(dbg_pkg::IR_MEM_ADDR);
		fork
			jtag_dr(ADDR_W, '0, dout);
			begin
				step(130);
				arm_mark = 1'b1;
				step(1);
				arm_mark = 1'b0;
				repeat (CAP_SAMPLES) begin
					rng = xorshift(rng);
					sample = rng[7:0];
					sample_valid = 1'b1;
					step(1);
				end
				sample_valid = 1'b0;
			end
		join
		jtag_ir(dbg_pkg::IR_MEM_DATA);
		jtag_dr(8, '0, dout);
		report(K_SAMPLE, 0, dout[7:0]);
		end_test("read_during_capture");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
			tests_run, tests_failed, check_count, err_count);
		if (tests_failed == 0 && err_count == 0 && other_errors == 0 && check_count > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== debug_top.f ====
design/dbg_pkg.sv
design/jtag_tap.sv
design/dbg_regfile.sv
design/sample_buffer.sv
design/capture_engine.sv
design/prbs_checker.sv
design/debug_top.sv
verif/debug_checker.sv
verif/debug_tb.sv

// ==== Bender.yml ====
package:
  name: debug_top

sources:
  - design/dbg_pkg.sv
  - design/jtag_tap.sv
  - design/dbg_regfile.sv
  - design/sample_buffer.sv
  - design/capture_engine.sv
  - design/prbs_checker.sv
  - design/debug_top.sv
  - target: test
    files:
      - verif/debug_checker.sv
      - verif/debug_tb.sv
